/* hdl/isa_pkg.sv */
// RV32 instruction encodings
package isa_pkg;

    // major opcode field, bits 6:0 of every RV32 instruction
    typedef logic [6:0] opcode_t;

    // full instruction word
    typedef logic [31:0] inst_t;

    // control transfer
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // memory access
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;

endpackage

/* hdl/sentry_pkg.sv */
// Operand routing types and line geometry
package sentry_pkg;

    // byte address of a fetched instruction
    typedef logic [31:0] addr_t;

    // result or load/store data value
    typedef logic [31:0] data_t;

    // instruction tag from the front end
    typedef logic [7:0] tag_t;

    // instructions held in one cache line
    localparam int LINE_INSTS = 8;

    // one full instruction line, word 0 in the low bits
    typedef logic [LINE_INSTS*$bits(isa_pkg::inst_t)-1:0] line_t;

    // word position inside a line
    typedef logic [$clog2(LINE_INSTS)-1:0] offset_t;

    // address layout: | tag | index | word offset | byte offset |
    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB  = OFFSET_LSB + $clog2(LINE_INSTS);

    // program counter value coming out of reset
    localparam addr_t START_PC = 32'h0000_1000;

endpackage

/* hdl/stage_if.sv */
// Pipeline stage interfaces
`timescale 1ns/1ps

// line store requests from intake
interface store_if import sentry_pkg::*; #(
    parameter int INDEX_WIDTH = 4
) ();
    logic                   wr_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    line_t                  wr_line;
    logic [INDEX_WIDTH-1:0] rd_index;

    modport intake (output wr_en, wr_index, wr_line, rd_index);
    modport store  (input  wr_en, wr_index, wr_line, rd_index);
endinterface

// accepted header, one cycle after intake
interface fetch_if import sentry_pkg::*; ();
    logic       valid;
    logic       miss;
    offset_t    offset;
    data_t      result;
    tag_t       tag;
    line_t      miss_line;

    modport source (output valid, miss, offset, result, tag, miss_line);
    modport sink   (input  valid, miss, offset, result, tag, miss_line);
endinterface

// issue queue write side
interface entry_if import sentry_pkg::*; import isa_pkg::*; ();
    logic   wr_en;
    addr_t  pc;
    inst_t  inst;
    data_t  result;
    tag_t   tag;
    logic   is_mem;

    modport source (output wr_en, pc, inst, result, tag, is_mem);
    modport sink   (input  wr_en, pc, inst, result, tag, is_mem);
endinterface

// issue queue head, seen by the router
interface head_if import sentry_pkg::*; import isa_pkg::*; ();
    logic   empty;
    addr_t  pc;
    inst_t  inst;
    data_t  result;
    tag_t   tag;
    logic   is_mem;
    logic   rd_en;

    modport queue  (output empty, pc, inst, result, tag, is_mem, input  rd_en);
    modport router (input  empty, pc, inst, result, tag, is_mem, output rd_en);
endinterface

/* hdl/packet_intake.sv */
// Instruction packet intake
`timescale 1ns/1ps

module packet_intake import sentry_pkg::*; #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic    clk,
    input  logic    rst,
    // instruction header FIFO
    input  logic    inst_hdr_empty,
    input  logic    inst_hdr_miss,
    input  addr_t   inst_hdr_addr,
    input  data_t   inst_hdr_result,
    input  tag_t    inst_hdr_tag,
    output logic    inst_hdr_rd_en,
    // instruction line FIFO
    input  logic    inst_line_empty,
    input  line_t   inst_line_data,
    output logic    inst_line_rd_en,
    // back-pressure
    input  logic    unit_ready,
    input  logic    prog_full,
    store_if.intake store,
    fetch_if.source fetch
);

    logic                   hdr_ready;
    logic                   accept;
    logic [INDEX_WIDTH-1:0] line_index;

    // a miss header also needs its line packet
    assign hdr_ready = !inst_hdr_empty && (!inst_hdr_miss || !inst_line_empty);
    assign accept    = hdr_ready && unit_ready && !prog_full;

    assign inst_hdr_rd_en  = accept;
    assign inst_line_rd_en = accept && inst_hdr_miss;

    assign line_index = inst_hdr_addr[INDEX_LSB +: INDEX_WIDTH];

    // store requests, cycle 0
    assign store.wr_en    = accept && inst_hdr_miss;
    assign store.wr_index = line_index;
    assign store.wr_line  = inst_line_data;
    assign store.rd_index = line_index;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= accept;
        end
    end

    // header fields into cycle 1
    always_ff @(posedge clk) begin
        fetch.miss      <= inst_hdr_miss;
        fetch.offset    <= inst_hdr_addr[OFFSET_LSB +: $bits(offset_t)];
        fetch.result    <= inst_hdr_result;
        fetch.tag       <= inst_hdr_tag;
        fetch.miss_line <= inst_line_data;
    end

endmodule

/* hdl/line_store.sv */
// Direct-mapped instruction line store
`timescale 1ns/1ps

module line_store import sentry_pkg::*; #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic    clk,
    store_if.store  store,
    output line_t   rd_line
);

    line_t                  mem [2**INDEX_WIDTH];

    // write held for one cycle before commit
    logic                   pend_en;
    logic [INDEX_WIDTH-1:0] pend_index;
    line_t                  pend_line;

    always_ff @(posedge clk) begin
        pend_en    <= store.wr_en;
        pend_index <= store.wr_index;
        pend_line  <= store.wr_line;
    end

    always_ff @(posedge clk) begin
        if (pend_en) begin
            mem[pend_index] <= pend_line;
        end
    end

    // pending line wins over the array, covers a hit right after its miss
    always_ff @(posedge clk) begin
        if (pend_en && (store.rd_index == pend_index)) begin
            rd_line <= pend_line;
        end else begin
            rd_line <= mem[store.rd_index];
        end
    end

endmodule

/* hdl/inst_select.sv */
// Instruction select and PC rebuild
`timescale 1ns/1ps

module inst_select import sentry_pkg::*; import isa_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  line_t   rd_line,
    fetch_if.sink   fetch,
    entry_if.source entry
);

    line_t      cur_line;
    inst_t      cur_inst;
    opcode_t    opcode;
    logic       is_jump;
    logic       is_mem;
    addr_t      pc;

    // miss line comes from the packet, hit line from the store
    assign cur_line = fetch.miss ? fetch.miss_line : rd_line;
    assign cur_inst = cur_line[fetch.offset*$bits(inst_t) +: $bits(inst_t)];
    assign opcode   = cur_inst[$bits(opcode_t)-1:0];

    assign is_jump = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH);
    assign is_mem  = (opcode == OP_LOAD) || (opcode == OP_STORE);

    // jumps take the checked result as the next pc
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= START_PC;
        end else if (fetch.valid) begin
            if (is_jump) begin
                pc <= addr_t'(fetch.result);
            end else begin
                pc <= pc + addr_t'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry.wr_en <= 1'b0;
        end else begin
            entry.wr_en <= fetch.valid;
        end
    end

    // entry payload, cycle 2
    always_ff @(posedge clk) begin
        entry.pc     <= pc;
        entry.inst   <= cur_inst;
        entry.result <= fetch.result;
        entry.tag    <= fetch.tag;
        entry.is_mem <= is_mem;
    end

endmodule

/* hdl/issue_queue.sv */
// Show-ahead issue queue
`timescale 1ns/1ps

module issue_queue import sentry_pkg::*; import isa_pkg::*; #(
    parameter int QUEUE_DEPTH     = 16,
    parameter int PROG_FULL_LEVEL = 12
) (
    input  logic    clk,
    input  logic    rst,
    output logic    prog_full,
    entry_if.sink   entry,
    head_if.queue   head
);

    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W = $clog2(QUEUE_DEPTH + 1);

    addr_t  pc_mem     [QUEUE_DEPTH];
    inst_t  inst_mem   [QUEUE_DEPTH];
    data_t  result_mem [QUEUE_DEPTH];
    tag_t   tag_mem    [QUEUE_DEPTH];
    logic   is_mem_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full       = count == COUNT_W'(QUEUE_DEPTH);
    assign head.empty = count == '0;
    assign prog_full  = count >= COUNT_W'(PROG_FULL_LEVEL);

    assign do_wr = entry.wr_en && !full;
    assign do_rd = head.rd_en && !head.empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            pc_mem[wr_ptr]     <= entry.pc;
            inst_mem[wr_ptr]   <= entry.inst;
            result_mem[wr_ptr] <= entry.result;
            tag_mem[wr_ptr]    <= entry.tag;
            is_mem_mem[wr_ptr] <= entry.is_mem;
        end
    end

    // head is valid whenever the queue is not empty
    assign head.pc     = pc_mem[rd_ptr];
    assign head.inst   = inst_mem[rd_ptr];
    assign head.result = result_mem[rd_ptr];
    assign head.tag    = tag_mem[rd_ptr];
    assign head.is_mem = is_mem_mem[rd_ptr];

endmodule

/* hdl/data_router.sv */
// Issue and data header routing
`timescale 1ns/1ps

module data_router import sentry_pkg::*; import isa_pkg::*; (
    // data header FIFO
    input  logic    data_hdr_empty,
    input  data_t   data_hdr_value,
    output logic    data_hdr_rd_en,
    // load/store unit FIFO
    output logic    lsu_wr_en,
    output data_t   lsu_data,
    input  logic    lsu_almost_full,
    // issue port
    output logic    issue_valid,
    output addr_t   issue_pc,
    output inst_t   issue_inst,
    output data_t   issue_result,
    output tag_t    issue_tag,
    head_if.router  head
);

    logic data_ready;
    logic qualify;
    logic mem_issue;

    // memory instructions wait for their data header
    assign data_ready = !head.is_mem || !data_hdr_empty;
    assign qualify    = !head.empty && !lsu_almost_full && data_ready;
    assign mem_issue  = qualify && head.is_mem;

    assign head.rd_en = qualify;

    assign issue_valid  = qualify;
    assign issue_pc     = head.pc;
    assign issue_inst   = head.inst;
    assign issue_result = head.result;
    assign issue_tag    = head.tag;

    // forward the data header in the issue cycle
    assign data_hdr_rd_en = mem_issue;
    assign lsu_wr_en      = mem_issue;
    assign lsu_data       = data_hdr_value;

endmodule

/* hdl/operand_router.sv */
// Operand routing stage top level
`timescale 1ns/1ps

module operand_router import sentry_pkg::*; import isa_pkg::*; #(
    parameter int INDEX_WIDTH     = 4,
    parameter int QUEUE_DEPTH     = 16,
    parameter int PROG_FULL_LEVEL = 12
) (
    input  logic    clk,
    input  logic    rst,
    // instruction header FIFO
    input  logic    inst_hdr_empty,
    input  logic    inst_hdr_miss,
    input  addr_t   inst_hdr_addr,
    input  data_t   inst_hdr_result,
    input  tag_t    inst_hdr_tag,
    output logic    inst_hdr_rd_en,
    // instruction line FIFO
    input  logic    inst_line_empty,
    input  line_t   inst_line_data,
    output logic    inst_line_rd_en,
    // data header FIFO
    input  logic    data_hdr_empty,
    input  data_t   data_hdr_value,
    output logic    data_hdr_rd_en,
    // load/store unit FIFO
    output logic    lsu_wr_en,
    output data_t   lsu_data,
    input  logic    lsu_almost_full,
    // issue
    output logic    issue_valid,
    output addr_t   issue_pc,
    output inst_t   issue_inst,
    output data_t   issue_result,
    output tag_t    issue_tag,
    input  logic    unit_ready
);

    line_t  rd_line;
    logic   prog_full;

    store_if #(.INDEX_WIDTH(INDEX_WIDTH)) u_store_if ();
    fetch_if u_fetch_if ();
    entry_if u_entry_if ();
    head_if  u_head_if ();

    packet_intake #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_packet_intake (
        .clk             (clk),
        .rst             (rst),
        .inst_hdr_empty  (inst_hdr_empty),
        .inst_hdr_miss   (inst_hdr_miss),
        .inst_hdr_addr   (inst_hdr_addr),
        .inst_hdr_result (inst_hdr_result),
        .inst_hdr_tag    (inst_hdr_tag),
        .inst_hdr_rd_en  (inst_hdr_rd_en),
        .inst_line_empty (inst_line_empty),
        .inst_line_data  (inst_line_data),
        .inst_line_rd_en (inst_line_rd_en),
        .unit_ready      (unit_ready),
        .prog_full       (prog_full),
        .store           (u_store_if.intake),
        .fetch           (u_fetch_if.source)
    );

    line_store #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_line_store (
        .clk     (clk),
        .store   (u_store_if.store),
        .rd_line (rd_line)
    );

    inst_select u_inst_select (
        .clk     (clk),
        .rst     (rst),
        .rd_line (rd_line),
        .fetch   (u_fetch_if.sink),
        .entry   (u_entry_if.source)
    );

    issue_queue #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
    ) u_issue_queue (
        .clk       (clk),
        .rst       (rst),
        .prog_full (prog_full),
        .entry     (u_entry_if.sink),
        .head      (u_head_if.queue)
    );

    data_router u_data_router (
        .data_hdr_empty  (data_hdr_empty),
        .data_hdr_value  (data_hdr_value),
        .data_hdr_rd_en  (data_hdr_rd_en),
        .lsu_wr_en       (lsu_wr_en),
        .lsu_data        (lsu_data),
        .lsu_almost_full (lsu_almost_full),
        .issue_valid     (issue_valid),
        .issue_pc        (issue_pc),
        .issue_inst      (issue_inst),
        .issue_result    (issue_result),
        .issue_tag       (issue_tag),
        .head            (u_head_if.router)
    );

endmodule

/* bench/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* bench/tb_operand_router.sv */
// Operand router testbench
`timescale 1ns/1ps

module tb_operand_router import sentry_pkg::*; import isa_pkg::*; ();

    localparam int INDEX_WIDTH       = 4;
    localparam int NUM_LINES         = 2**INDEX_WIDTH;
    localparam int NUM_PACKETS       = 200;
    localparam int CYCLES_PER_PACKET = 40;
    localparam int CLK_PERIOD        = 4;

    typedef struct packed {
        logic  miss;
        addr_t addr;
        data_t result;
        tag_t  tag;
    } header_t;

    typedef struct packed {
        logic  miss;
        logic  mem;
        addr_t pc;
        inst_t inst;
        data_t result;
        tag_t  tag;
    } expect_t;

    logic   clk;
    logic   rst;
    logic   inst_hdr_empty;
    logic   inst_hdr_miss;
    addr_t  inst_hdr_addr;
    data_t  inst_hdr_result;
    tag_t   inst_hdr_tag;
    logic   inst_hdr_rd_en;
    logic   inst_line_empty;
    line_t  inst_line_data;
    logic   inst_line_rd_en;
    logic   data_hdr_empty;
    data_t  data_hdr_value;
    logic   data_hdr_rd_en;
    logic   lsu_wr_en;
    data_t  lsu_data;
    logic   lsu_almost_full;
    logic   issue_valid;
    addr_t  issue_pc;
    inst_t  issue_inst;
    data_t  issue_result;
    tag_t   issue_tag;
    logic   unit_ready;

    // input FIFO contents with the head at index 0
    header_t hdr_q [$];
    line_t   line_q [$];
    data_t   data_q [$];
    data_t   data_pend_q [$];

    // reference model state
    expect_t exp_q [$];
    data_t   exp_data_q [$];
    line_t   lines [NUM_LINES];
    addr_t   model_pc;
    logic    last_miss;
    int      last_idx;
    int      last_cycle;

    logic [15:0] lfsr;
    int          cycle;
    int          af_hold;
    int          acc_cnt;
    int          iss_cnt;
    int          bypass_cnt;
    int          err_cnt [1:5];
    int          chk_cnt [1:5];
    string       test_name [1:5];

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(8)) u_clock (.clk(clk), .rst(rst));

    operand_router #(
        .INDEX_WIDTH     (INDEX_WIDTH),
        .QUEUE_DEPTH     (16),
        .PROG_FULL_LEVEL (12)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .inst_hdr_empty  (inst_hdr_empty),
        .inst_hdr_miss   (inst_hdr_miss),
        .inst_hdr_addr   (inst_hdr_addr),
        .inst_hdr_result (inst_hdr_result),
        .inst_hdr_tag    (inst_hdr_tag),
        .inst_hdr_rd_en  (inst_hdr_rd_en),
        .inst_line_empty (inst_line_empty),
        .inst_line_data  (inst_line_data),
        .inst_line_rd_en (inst_line_rd_en),
        .data_hdr_empty  (data_hdr_empty),
        .data_hdr_value  (data_hdr_value),
        .data_hdr_rd_en  (data_hdr_rd_en),
        .lsu_wr_en       (lsu_wr_en),
        .lsu_data        (lsu_data),
        .lsu_almost_full (lsu_almost_full),
        .issue_valid     (issue_valid),
        .issue_pc        (issue_pc),
        .issue_inst      (issue_inst),
        .issue_result    (issue_result),
        .issue_tag       (issue_tag),
        .unit_ready      (unit_ready)
    );

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic jump_op(input inst_t w);
        return (w[6:0] == OP_JAL) || (w[6:0] == OP_JALR) || (w[6:0] == OP_BRANCH);
    endfunction

    function automatic logic mem_op(input inst_t w);
        return (w[6:0] == OP_LOAD) || (w[6:0] == OP_STORE);
    endfunction

    // jump, memory or plain ALU word with random upper fields
    function automatic inst_t make_inst();
        opcode_t     op;
        logic [31:0] kind;
        kind = rand_bits(2);
        if (kind == 0) begin
            op = rand_bits(1) ? OP_JAL : (rand_bits(1) ? OP_JALR : OP_BRANCH);
        end else if (kind == 1) begin
            op = rand_bits(1) ? OP_LOAD : OP_STORE;
        end else begin
            op = rand_bits(1) ? 7'b0110011 : 7'b0010011;
        end
        return inst_t'(rand_bits(25) << 7) | inst_t'(op);
    endfunction

    function automatic line_t make_line();
        line_t line;
        for (int w = 0; w < LINE_INSTS; w++) begin
            line[w*32 +: 32] = make_inst();
        end
        return line;
    endfunction

    task automatic report_mismatch(input int t, input string name,
                                   input logic [31:0] got, input logic [31:0] exp);
        err_cnt[t]++;
        $display("CHECK FAILED at %0d ns: %s = %h, expected %h (test %0d)",
                 $time, name, got, exp, t);
    endtask

    task automatic report_error(input int t, input string msg);
        err_cnt[t]++;
        $display("ERROR at %0d ns: %s (test %0d)", $time, msg, t);
    endtask

    // hits only go to lines that an earlier miss has written
    task automatic build_stimulus();
        header_t                h;
        logic [NUM_LINES-1:0]   written;
        int                     idx;
        int                     off;
        int                     last_miss_idx;
        written       = '0;
        last_miss_idx = 0;
        for (int n = 0; n < NUM_PACKETS; n++) begin
            h.miss = (written == '0) || rand_bits(1);
            if (h.miss) begin
                idx           = int'(rand_bits(INDEX_WIDTH));
                last_miss_idx = idx;
                written[idx]  = 1'b1;
                line_q.push_back(make_line());
            end else if (rand_bits(1)) begin
                // often lands right behind its miss
                idx = last_miss_idx;
            end else begin
                idx = int'(rand_bits(INDEX_WIDTH));
                while (!written[idx]) begin
                    idx = (idx + 1) % NUM_LINES;
                end
            end
            off      = int'(rand_bits(3));
            h.addr   = addr_t'(rand_bits(32 - INDEX_LSB - INDEX_WIDTH)
                               << (INDEX_LSB + INDEX_WIDTH))
                     | addr_t'(idx << INDEX_LSB) | addr_t'(off << OFFSET_LSB);
            h.result = data_t'(rand_bits(30) << 2);
            h.tag    = tag_t'(n);
            hdr_q.push_back(h);
        end
    endtask

    // reference model step for one accepted header
    task automatic take_header();
        header_t h;
        expect_t e;
        line_t   line;
        int      idx;
        int      off;
        data_t   d;
        if (inst_hdr_empty) begin
            report_error(5, "inst_hdr_rd_en raised while the header FIFO was empty");
        end else begin
            if (!unit_ready) begin
                report_error(5, "header popped while unit_ready was low");
            end
            if (inst_line_rd_en !== inst_hdr_miss) begin
                report_error(1, "inst_line_rd_en does not follow the header miss flag");
            end
            h   = hdr_q.pop_front();
            idx = int'((h.addr >> INDEX_LSB) & addr_t'(NUM_LINES - 1));
            off = int'((h.addr >> OFFSET_LSB) & addr_t'(LINE_INSTS - 1));
            if (h.miss) begin
                line       = line_q.pop_front();
                lines[idx] = line;
            end else begin
                line = lines[idx];
                if (last_miss && last_idx == idx && last_cycle == cycle - 1) begin
                    bypass_cnt++;
                end
            end
            e.miss   = h.miss;
            e.inst   = line[off*32 +: 32];
            e.mem    = mem_op(e.inst);
            e.pc     = model_pc;
            e.result = h.result;
            e.tag    = h.tag;
            exp_q.push_back(e);
            model_pc = jump_op(e.inst) ? addr_t'(h.result) : model_pc + 4;
            if (e.mem) begin
                d = data_t'(rand_bits(32));
                data_pend_q.push_back(d);
                exp_data_q.push_back(d);
            end
            last_miss  = h.miss;
            last_idx   = idx;
            last_cycle = cycle;
            acc_cnt++;
        end
    endtask

    task automatic check_issue();
        expect_t e;
        data_t   d;
        int      t;
        if (issue_valid && lsu_almost_full) begin
            report_error(5, "issue_valid high while lsu_almost_full was high");
        end
        if (!issue_valid) begin
            if (lsu_wr_en || data_hdr_rd_en) begin
                report_error(4, "data header moved without an issue");
            end
        end else if (exp_q.size() == 0) begin
            report_error(5, "issue_valid with no accepted header outstanding");
        end else begin
            e = exp_q.pop_front();
            t = e.miss ? 1 : 2;
            chk_cnt[t]++;
            chk_cnt[3]++;
            chk_cnt[5]++;
            if (issue_inst !== e.inst) begin
                report_mismatch(t, "issue_inst", issue_inst, e.inst);
            end
            if (issue_result !== e.result) begin
                report_mismatch(t, "issue_result", issue_result, e.result);
            end
            if (issue_tag !== e.tag) begin
                report_mismatch(t, "issue_tag", 32'(issue_tag), 32'(e.tag));
            end
            if (issue_pc !== e.pc) begin
                report_mismatch(3, "issue_pc", issue_pc, e.pc);
            end
            if (issue_tag !== tag_t'(iss_cnt)) begin
                report_mismatch(5, "issue_tag", 32'(issue_tag), 32'(tag_t'(iss_cnt)));
            end
            if (e.mem) begin
                chk_cnt[4]++;
                d = exp_data_q.pop_front();
                if (!lsu_wr_en || !data_hdr_rd_en) begin
                    report_error(4, "memory issue without a data header pop and lsu write");
                end else if (lsu_data !== d) begin
                    report_mismatch(4, "lsu_data", lsu_data, d);
                end
            end else if (lsu_wr_en || data_hdr_rd_en) begin
                report_error(4, "non-memory issue touched the data header FIFO");
            end
            iss_cnt++;
        end
    endtask

    // bursts of lsu_almost_full so the queue fills up at times
    task automatic draw_backpressure();
        logic af_next;
        if (af_hold > 0) begin
            af_hold--;
            af_next = 1'b1;
        end else if (rand_bits(4) == 0) begin
            af_hold = int'(rand_bits(4));
            af_next = 1'b1;
        end else begin
            af_next = 1'b0;
        end
        unit_ready      <= (rand_bits(2) != 0);
        lsu_almost_full <= af_next;
    endtask

    task automatic drive_fifos();
        inst_hdr_empty  <= (hdr_q.size() == 0);
        inst_line_empty <= (line_q.size() == 0);
        data_hdr_empty  <= (data_q.size() == 0);
        if (hdr_q.size() > 0) begin
            inst_hdr_miss   <= hdr_q[0].miss;
            inst_hdr_addr   <= hdr_q[0].addr;
            inst_hdr_result <= hdr_q[0].result;
            inst_hdr_tag    <= hdr_q[0].tag;
        end
        if (line_q.size() > 0) begin
            inst_line_data <= line_q[0];
        end
        if (data_q.size() > 0) begin
            data_hdr_value <= data_q[0];
        end
    endtask

    // outputs read here are the settled values from before the edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst) begin
            check_issue();
            if (inst_hdr_rd_en) begin
                take_header();
            end else if (inst_line_rd_en) begin
                report_error(1, "inst_line_rd_en raised without a header pop");
            end
            if (inst_line_rd_en && inst_line_empty) begin
                report_error(1, "inst_line_rd_en raised while the line FIFO was empty");
            end
            if (data_hdr_rd_en) begin
                if (data_hdr_empty) begin
                    report_error(4, "data_hdr_rd_en raised while the data FIFO was empty");
                end else begin
                    data_q.delete(0);
                end
            end
            // random arrival delay of data headers
            if (data_pend_q.size() > 0 && rand_bits(1)) begin
                data_q.push_back(data_pend_q.pop_front());
            end
            draw_backpressure();
            drive_fifos();
        end
    end

    initial begin
        #(NUM_PACKETS * CYCLES_PER_PACKET * CLK_PERIOD);
        $display("watchdog: run did not drain within %0d cycles",
                 NUM_PACKETS * CYCLES_PER_PACKET);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int total_chk;
        int total_err;
        lfsr            = 16'd57;
        model_pc        = START_PC;
        last_miss       = 1'b0;
        inst_hdr_empty  = 1'b1;
        inst_hdr_miss   = 1'b0;
        inst_hdr_addr   = '0;
        inst_hdr_result = '0;
        inst_hdr_tag    = '0;
        inst_line_empty = 1'b1;
        inst_line_data  = '0;
        data_hdr_empty  = 1'b1;
        data_hdr_value  = '0;
        lsu_almost_full = 1'b0;
        unit_ready      = 1'b0;
        test_name[1]    = "miss issue";
        test_name[2]    = "hit and bypass";
        test_name[3]    = "pc sequence";
        test_name[4]    = "data forwarding";
        test_name[5]    = "back-pressure";
        build_stimulus();

        wait (rst === 1'b0);
        while (hdr_q.size() > 0 || exp_q.size() > 0) begin
            @(posedge clk);
        end
        // quiet window where any further issue is an error
        repeat (10) @(posedge clk);

        chk_cnt[2]++;
        if (bypass_cnt == 0) begin
            report_error(2, "no hit was accepted right after a miss to its line");
        end
        chk_cnt[4]++;
        if (data_q.size() != 0 || data_pend_q.size() != 0) begin
            report_error(4, "data headers left over after the drain");
        end
        chk_cnt[5]++;
        if (acc_cnt != NUM_PACKETS || iss_cnt != acc_cnt) begin
            report_error(5, $sformatf("%0d packets, %0d accepted, %0d issued",
                                      NUM_PACKETS, acc_cnt, iss_cnt));
        end

        total_chk = 0;
        total_err = 0;
        for (int t = 1; t <= 5; t++) begin
            total_chk += chk_cnt[t];
            total_err += err_cnt[t];
            $display("test %0d %s: %0d checks, %0d errors, %s", t, test_name[t],
                     chk_cnt[t], err_cnt[t], (err_cnt[t] == 0) ? "ok" : "FAILED");
        end
        $display("%0d checks, %0d errors, %0d issued, %0d bypass hits",
                 total_chk, total_err, iss_cnt, bypass_cnt);
        if (total_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hdl/isa_pkg.sv
hdl/sentry_pkg.sv
hdl/stage_if.sv
hdl/packet_intake.sv
hdl/line_store.sv
hdl/inst_select.sv
hdl/issue_queue.sv
hdl/data_router.sv
hdl/operand_router.sv
bench/tb_clock.sv
bench/tb_operand_router.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_operand_router \
    -f tb.f -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && grep -q "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
